// File: hdl/issue_pkg.sv
package issue_pkg;

  // Execution class of a decoded instruction that selects the target unit
  typedef enum logic [2:0] {
    class_alu    = 3'd0,
    class_muldiv = 3'd1,
    class_load   = 3'd2,
    class_store  = 3'd3,
    class_branch = 3'd4,
    class_jump   = 3'd5
  } inst_class_e;

  // The ordered branch conditions test signed A against zero
  typedef enum logic [2:0] {
    cond_unconditional = 3'd0,
    cond_eq            = 3'd1,
    cond_ne            = 3'd2,
    cond_gt            = 3'd3,
    cond_ge            = 3'd4,
    cond_lt            = 3'd5,
    cond_le            = 3'd6
  } branch_cond_e;

  typedef struct packed {
    logic [31:0]  pc;
    logic [31:0]  branch_target;
    logic [4:0]   a_reg;
    logic         a_reg_valid;
    logic [4:0]   b_reg;
    logic         b_reg_valid;
    logic [4:0]   dest_reg;
    logic         dest_reg_valid;
    inst_class_e  inst_class;
    branch_cond_e branch_cond;
    // Jump target comes from operand A instead of branch_target
    logic         reg_target;
  } dec_inst_t;

  // Answer of the ROB associative lookup for one queue slot
  typedef struct packed {
    logic [31:0] a_value;
    logic [31:0] b_value;
    logic        a_present;
    logic        a_valid;
    logic        b_present;
    logic        b_valid;
  } rob_lookup_t;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
  } operand_pair_t;

  // Everything a unit needs to start an instruction
  typedef struct packed {
    dec_inst_t     inst;
    operand_pair_t operands;
  } issue_op_t;

  // Link write from the branch resolver into the ROB
  typedef struct packed {
    logic [31:0] result;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
    logic        pc_valid;
  } rob_write_t;

endpackage

// File: hdl/operand_gather.sv
`timescale 1ns/1ps

module operand_gather (
  input  issue_pkg::dec_inst_t     inst[4],
  input  issue_pkg::rob_lookup_t   lookup[4],
  input  logic [31:0]              reg_data[8],
  output issue_pkg::operand_pair_t operands[4],
  output logic                     operands_ready[4]
);

  logic a_usable[4];
  logic b_usable[4];

  for (genvar i = 0; i < 4; i++) begin : g_slot
    // A newer value in the ROB overrides the register file copy
    assign operands[i].a = lookup[i].a_present ? lookup[i].a_value : reg_data[2*i];
    assign operands[i].b = lookup[i].b_present ? lookup[i].b_value : reg_data[2*i+1];

    // Either the register file is current or the ROB has already produced the value
    assign a_usable[i] = ~lookup[i].a_present | lookup[i].a_valid;
    assign b_usable[i] = ~lookup[i].b_present | lookup[i].b_valid;

    // Operands the instruction does not read never hold it back
    assign operands_ready[i] = (a_usable[i] | ~inst[i].a_reg_valid) &
                               (b_usable[i] | ~inst[i].b_reg_valid);
  end

endmodule

// File: hdl/issue_select.sv
`timescale 1ns/1ps

module issue_select #(
  parameter int rob_index_width = 4
) (
  input  logic                         entry_valid[4],
  input  issue_pkg::dec_inst_t         entry_inst[4],
  input  logic [rob_index_width-1:0]   entry_rob_slot[4],
  input  issue_pkg::operand_pair_t     operands[4],
  input  logic                         operands_ready[4],
  input  logic                         ls_ready,
  input  logic                         alu_ready,
  input  logic                         muldiv_ready,
  input  logic                         branch_ready,
  output logic                         consume_enable,
  output logic [1:0]                   consume_count,
  output issue_pkg::issue_op_t         ls_op,
  output logic [rob_index_width-1:0]   ls_rob_slot,
  output logic                         ls_valid,
  output issue_pkg::issue_op_t         alu_op,
  output logic [rob_index_width-1:0]   alu_rob_slot,
  output logic                         alu_valid,
  output issue_pkg::issue_op_t         muldiv_op,
  output logic [rob_index_width-1:0]   muldiv_rob_slot,
  output logic                         muldiv_valid,
  output issue_pkg::issue_op_t         branch_op,
  output logic [rob_index_width-1:0]   branch_rob_slot,
  output logic                         branch_issue
);

  issue_pkg::issue_op_t slot_op[4];
  logic                 delay_slot_ok[4];

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      slot_op[i].inst     = entry_inst[i];
      slot_op[i].operands = operands[i];
    end
    // A branch may only leave together with its delay slot instruction
    for (int i = 0; i < 3; i++) begin
      delay_slot_ok[i] = entry_valid[i + 1];
    end
    delay_slot_ok[3] = 1'b0;
  end

  always_comb begin
    logic       stop;
    logic [2:0] count;
    logic [2:0] count_minus_one;

    stop            = 1'b0;
    count           = 3'd0;
    ls_valid        = 1'b0;
    alu_valid       = 1'b0;
    muldiv_valid    = 1'b0;
    branch_issue    = 1'b0;
    ls_op           = slot_op[0];
    alu_op          = slot_op[0];
    muldiv_op       = slot_op[0];
    branch_op       = slot_op[0];
    ls_rob_slot     = entry_rob_slot[0];
    alu_rob_slot    = entry_rob_slot[0];
    muldiv_rob_slot = entry_rob_slot[0];
    branch_rob_slot = entry_rob_slot[0];

    // Issue stays in order because the first slot that cannot leave blocks all later ones
    for (int i = 0; i < 4; i++) begin
      if (!stop) begin
        if (!entry_valid[i] || !operands_ready[i]) begin
          stop = 1'b1;
        end else begin
          case (entry_inst[i].inst_class)
            issue_pkg::class_branch, issue_pkg::class_jump: begin
              if (!branch_issue && branch_ready && delay_slot_ok[i]) begin
                branch_issue    = 1'b1;
                branch_op       = slot_op[i];
                branch_rob_slot = entry_rob_slot[i];
              end else begin
                stop = 1'b1;
              end
            end
            issue_pkg::class_load, issue_pkg::class_store: begin
              if (!ls_valid && ls_ready) begin
                ls_valid    = 1'b1;
                ls_op       = slot_op[i];
                ls_rob_slot = entry_rob_slot[i];
              end else begin
                stop = 1'b1;
              end
            end
            issue_pkg::class_muldiv: begin
              if (!muldiv_valid && muldiv_ready) begin
                muldiv_valid    = 1'b1;
                muldiv_op       = slot_op[i];
                muldiv_rob_slot = entry_rob_slot[i];
              end else begin
                stop = 1'b1;
              end
            end
            issue_pkg::class_alu: begin
              if (!alu_valid && alu_ready) begin
                alu_valid    = 1'b1;
                alu_op       = slot_op[i];
                alu_rob_slot = entry_rob_slot[i];
              end else if (!muldiv_valid && muldiv_ready) begin
                // The multiply/divide unit also executes plain ALU work
                muldiv_valid    = 1'b1;
                muldiv_op       = slot_op[i];
                muldiv_rob_slot = entry_rob_slot[i];
              end else begin
                stop = 1'b1;
              end
            end
            default: stop = 1'b1;
          endcase
          if (!stop) begin
            count = count + 3'd1;
          end
        end
      end
    end

    // The queue takes the count minus one, so four issued wraps to 3
    count_minus_one = count - 3'd1;
    consume_count   = count_minus_one[1:0];
    consume_enable  = (count != 3'd0);
  end

endmodule

// File: hdl/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve #(
  parameter int rob_index_width = 4
) (
  input  logic                         clock,
  input  logic                         reset_n,
  input  logic                         branch_stall,
  input  issue_pkg::issue_op_t         branch_op,
  input  logic [rob_index_width-1:0]   branch_rob_slot,
  input  logic                         branch_issue,
  output logic                         branch_ready,
  output logic [31:0]                  redirect_pc,
  output logic                         redirect_valid,
  output issue_pkg::rob_write_t        rob_write,
  output logic [rob_index_width-1:0]   rob_write_slot,
  output logic                         rob_write_valid
);

  logic                       stall_d;
  logic                       held_valid;
  issue_pkg::issue_op_t       held_op;
  logic [rob_index_width-1:0] held_slot;

  issue_pkg::issue_op_t       act_op;
  logic [rob_index_width-1:0] act_slot;
  logic                       act_valid;
  logic [31:0]                a;
  logic                       a_gez;
  logic                       a_gtz;
  logic                       cond_ok;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      stall_d    <= 1'b0;
      held_valid <= 1'b0;
    end else begin
      stall_d <= branch_stall;
      if (branch_stall && !stall_d) begin
        held_valid <= branch_issue;
      end
    end
  end

  // Snapshot of the branch in flight when fetch starts to stall
  always_ff @(posedge clock) begin
    if (branch_stall && !stall_d) begin
      held_op   <= branch_op;
      held_slot <= branch_rob_slot;
    end
  end

  assign branch_ready = ~stall_d;

  assign act_op    = stall_d ? held_op : branch_op;
  assign act_slot  = stall_d ? held_slot : branch_rob_slot;
  assign act_valid = stall_d ? held_valid : branch_issue;

  assign a     = act_op.operands.a;
  assign a_gez = ~a[31];
  assign a_gtz = a_gez & (a != 32'd0);

  always_comb begin
    case (act_op.inst.branch_cond)
      issue_pkg::cond_unconditional: cond_ok = 1'b1;
      issue_pkg::cond_eq:            cond_ok = (a == act_op.operands.b);
      issue_pkg::cond_ne:            cond_ok = (a != act_op.operands.b);
      issue_pkg::cond_gt:            cond_ok = a_gtz;
      issue_pkg::cond_ge:            cond_ok = a_gez;
      issue_pkg::cond_lt:            cond_ok = ~a_gez;
      issue_pkg::cond_le:            cond_ok = ~a_gtz;
      default:                       cond_ok = 1'b0;
    endcase
  end

  // Jumps always redirect, branches only when their condition holds
  assign redirect_valid = act_valid &
                          ((act_op.inst.inst_class == issue_pkg::class_jump) |
                           ((act_op.inst.inst_class == issue_pkg::class_branch) & cond_ok));
  assign redirect_pc    = act_op.inst.reg_target ? a : act_op.inst.branch_target;

  // Link skips the delay slot
  assign rob_write.result         = act_op.inst.pc + 32'd8;
  assign rob_write.dest_reg       = act_op.inst.dest_reg;
  assign rob_write.dest_reg_valid = act_op.inst.dest_reg_valid;
  assign rob_write.pc_valid       = redirect_valid;
  assign rob_write_slot           = act_slot;
  assign rob_write_valid          = ~branch_stall;

endmodule

// File: hdl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage #(
  parameter int rob_index_width = 4
) (
  input  logic                         clock,
  input  logic                         reset_n,
  input  logic                         entry_valid[4],
  input  issue_pkg::dec_inst_t         entry_inst[4],
  input  logic [rob_index_width-1:0]   entry_rob_slot[4],
  output logic                         consume_enable,
  output logic [1:0]                   consume_count,
  output logic [4:0]                   lookup_areg[4],
  output logic [4:0]                   lookup_breg[4],
  output logic [rob_index_width-1:0]   lookup_slot[4],
  input  issue_pkg::rob_lookup_t       lookup[4],
  output logic [4:0]                   reg_addr[8],
  input  logic [31:0]                  reg_data[8],
  output issue_pkg::issue_op_t         ls_op,
  output logic [rob_index_width-1:0]   ls_rob_slot,
  output logic                         ls_valid,
  input  logic                         ls_ready,
  output issue_pkg::issue_op_t         alu_op,
  output logic [rob_index_width-1:0]   alu_rob_slot,
  output logic                         alu_valid,
  input  logic                         alu_ready,
  output issue_pkg::issue_op_t         muldiv_op,
  output logic [rob_index_width-1:0]   muldiv_rob_slot,
  output logic                         muldiv_valid,
  input  logic                         muldiv_ready,
  input  logic                         branch_stall,
  output logic [31:0]                  redirect_pc,
  output logic                         redirect_valid,
  output issue_pkg::rob_write_t        rob_write,
  output logic [rob_index_width-1:0]   rob_write_slot,
  output logic                         rob_write_valid
);

  issue_pkg::operand_pair_t   operands[4];
  logic                       operands_ready[4];
  issue_pkg::issue_op_t       branch_op;
  logic [rob_index_width-1:0] branch_rob_slot;
  logic                       branch_issue;
  logic                       branch_ready;

  // Slot i reads A at register port 2i and B at port 2i+1
  for (genvar i = 0; i < 4; i++) begin : g_fanout
    assign lookup_areg[i]   = entry_inst[i].a_reg;
    assign lookup_breg[i]   = entry_inst[i].b_reg;
    assign lookup_slot[i]   = entry_rob_slot[i];
    assign reg_addr[2*i]    = entry_inst[i].a_reg;
    assign reg_addr[2*i+1]  = entry_inst[i].b_reg;
  end

  operand_gather i_operand_gather (
    .inst           (entry_inst),
    .lookup         (lookup),
    .reg_data       (reg_data),
    .operands       (operands),
    .operands_ready (operands_ready)
  );

  issue_select #(
    .rob_index_width (rob_index_width)
  ) i_issue_select (
    .entry_valid     (entry_valid),
    .entry_inst      (entry_inst),
    .entry_rob_slot  (entry_rob_slot),
    .operands        (operands),
    .operands_ready  (operands_ready),
    .ls_ready        (ls_ready),
    .alu_ready       (alu_ready),
    .muldiv_ready    (muldiv_ready),
    .branch_ready    (branch_ready),
    .consume_enable  (consume_enable),
    .consume_count   (consume_count),
    .ls_op           (ls_op),
    .ls_rob_slot     (ls_rob_slot),
    .ls_valid        (ls_valid),
    .alu_op          (alu_op),
    .alu_rob_slot    (alu_rob_slot),
    .alu_valid       (alu_valid),
    .muldiv_op       (muldiv_op),
    .muldiv_rob_slot (muldiv_rob_slot),
    .muldiv_valid    (muldiv_valid),
    .branch_op       (branch_op),
    .branch_rob_slot (branch_rob_slot),
    .branch_issue    (branch_issue)
  );

  branch_resolve #(
    .rob_index_width (rob_index_width)
  ) i_branch_resolve (
    .clock           (clock),
    .reset_n         (reset_n),
    .branch_stall    (branch_stall),
    .branch_op       (branch_op),
    .branch_rob_slot (branch_rob_slot),
    .branch_issue    (branch_issue),
    .branch_ready    (branch_ready),
    .redirect_pc     (redirect_pc),
    .redirect_valid  (redirect_valid),
    .rob_write       (rob_write),
    .rob_write_slot  (rob_write_slot),
    .rob_write_valid (rob_write_valid)
  );

endmodule

// File: tb/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb;

  localparam int slot_w        = 4;
  localparam int reset_cycles  = 4;
  localparam int mix_cycles    = 200;
  localparam int operand_cycles = 200;
  localparam int ready_cycles  = 200;
  localparam int delay_cycles  = 100;
  localparam int outcome_cycles = 300;
  localparam int stall_cycles  = 200;
  localparam int test_cycles   = mix_cycles + operand_cycles + ready_cycles + delay_cycles +
                                 outcome_cycles + stall_cycles;
  // The margin covers the extra half cycle at the end of each test and more
  localparam int watchdog_ns   = (reset_cycles + test_cycles + 6 + 20) * 8;

  // Expected combinational answer of the stage for one cycle
  typedef struct packed {
    logic                 consume_enable;
    logic [1:0]           consume_count;
    logic                 ls_valid;
    issue_pkg::issue_op_t ls_op;
    logic [slot_w-1:0]    ls_slot;
    logic                 alu_valid;
    issue_pkg::issue_op_t alu_op;
    logic [slot_w-1:0]    alu_slot;
    logic                 muldiv_valid;
    issue_pkg::issue_op_t muldiv_op;
    logic [slot_w-1:0]    muldiv_slot;
    logic                 br_issue;
    issue_pkg::issue_op_t br_op;
    logic [slot_w-1:0]    br_slot;
  } expect_t;

  logic                     clock;
  logic                     reset_n;
  logic                     entry_valid[4];
  issue_pkg::dec_inst_t     entry_inst[4];
  logic [slot_w-1:0]        entry_rob_slot[4];
  logic                     consume_enable;
  logic [1:0]               consume_count;
  logic [4:0]               lookup_areg[4];
  logic [4:0]               lookup_breg[4];
  logic [slot_w-1:0]        lookup_slot[4];
  issue_pkg::rob_lookup_t   lookup[4];
  logic [4:0]               reg_addr[8];
  logic [31:0]              reg_data[8];
  issue_pkg::issue_op_t     ls_op;
  logic [slot_w-1:0]        ls_rob_slot;
  logic                     ls_valid;
  logic                     ls_ready;
  issue_pkg::issue_op_t     alu_op;
  logic [slot_w-1:0]        alu_rob_slot;
  logic                     alu_valid;
  logic                     alu_ready;
  issue_pkg::issue_op_t     muldiv_op;
  logic [slot_w-1:0]        muldiv_rob_slot;
  logic                     muldiv_valid;
  logic                     muldiv_ready;
  logic                     branch_stall;
  logic [31:0]              redirect_pc;
  logic                     redirect_valid;
  issue_pkg::rob_write_t    rob_write;
  logic [slot_w-1:0]        rob_write_slot;
  logic                     rob_write_valid;

  // Model of the branch resolver state
  logic                     m_stall_d;
  logic                     m_held_valid;
  issue_pkg::issue_op_t     m_held_op;
  logic [slot_w-1:0]        m_held_slot;

  int check_count;
  int error_count;

  issue_stage #(
    .rob_index_width (slot_w)
  ) i_dut (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  task automatic check_value(input string name, input logic [159:0] got,
                             input logic [159:0] want);
    check_count++;
    assert (got === want) else begin
      error_count++;
      $display("Error %s: got %0h, expected %0h", name, got, want);
    end
  endtask

  function automatic logic branch_taken(input issue_pkg::issue_op_t op);
    logic signed [31:0] sa;
    sa = op.operands.a;
    case (op.inst.branch_cond)
      issue_pkg::cond_unconditional: return 1'b1;
      issue_pkg::cond_eq:            return op.operands.a == op.operands.b;
      issue_pkg::cond_ne:            return op.operands.a != op.operands.b;
      issue_pkg::cond_gt:            return sa > 0;
      issue_pkg::cond_ge:            return sa >= 0;
      issue_pkg::cond_lt:            return sa < 0;
      issue_pkg::cond_le:            return sa <= 0;
      default:                       return 1'b0;
    endcase
  endfunction

  // Applies the operand and in-order routing rules to the inputs of this cycle
  function automatic expect_t predict_issue(input logic br_ready);
    expect_t              e;
    issue_pkg::issue_op_t op;
    logic                 a_ok;
    logic                 b_ok;
    logic                 blocked;
    logic                 took;
    int                   issued;
    e       = '0;
    blocked = 1'b0;
    issued  = 0;
    for (int i = 0; i < 4; i++) begin
      op.inst       = entry_inst[i];
      op.operands.a = lookup[i].a_present ? lookup[i].a_value : reg_data[2*i];
      op.operands.b = lookup[i].b_present ? lookup[i].b_value : reg_data[2*i+1];
      a_ok = !entry_inst[i].a_reg_valid || !lookup[i].a_present || lookup[i].a_valid;
      b_ok = !entry_inst[i].b_reg_valid || !lookup[i].b_present || lookup[i].b_valid;
      took = 1'b0;
      if (!blocked && entry_valid[i] && a_ok && b_ok) begin
        case (entry_inst[i].inst_class)
          issue_pkg::class_branch, issue_pkg::class_jump: begin
            // The delay slot has to be in the queue beside the branch
            if (br_ready && i < 3 && entry_valid[(i + 1) % 4] && !e.br_issue) begin
              e.br_issue = 1'b1;
              e.br_op    = op;
              e.br_slot  = entry_rob_slot[i];
              took       = 1'b1;
            end
          end
          issue_pkg::class_load, issue_pkg::class_store: begin
            if (ls_ready && !e.ls_valid) begin
              e.ls_valid = 1'b1;
              e.ls_op    = op;
              e.ls_slot  = entry_rob_slot[i];
              took       = 1'b1;
            end
          end
          issue_pkg::class_muldiv: begin
            if (muldiv_ready && !e.muldiv_valid) begin
              e.muldiv_valid = 1'b1;
              e.muldiv_op    = op;
              e.muldiv_slot  = entry_rob_slot[i];
              took           = 1'b1;
            end
          end
          issue_pkg::class_alu: begin
            if (alu_ready && !e.alu_valid) begin
              e.alu_valid = 1'b1;
              e.alu_op    = op;
              e.alu_slot  = entry_rob_slot[i];
              took        = 1'b1;
            end else if (muldiv_ready && !e.muldiv_valid) begin
              e.muldiv_valid = 1'b1;
              e.muldiv_op    = op;
              e.muldiv_slot  = entry_rob_slot[i];
              took           = 1'b1;
            end
          end
          default: took = 1'b0;
        endcase
      end
      if (took) begin
        issued++;
      end else begin
        blocked = 1'b1;
      end
    end
    e.consume_enable = (issued > 0);
    e.consume_count  = 2'(issued - 1);
    return e;
  endfunction

  always @(negedge clock) begin : compare
    expect_t              e;
    issue_pkg::issue_op_t act_op;
    logic [slot_w-1:0]    act_slot;
    logic                 act_valid;
    logic                 want_redirect;
    if (!reset_n) begin
      m_stall_d    = 1'b0;
      m_held_valid = 1'b0;
    end else begin
      e = predict_issue(!m_stall_d);
      check_value("consume_enable", 160'(consume_enable), 160'(e.consume_enable));
      if (e.consume_enable) begin
        check_value("consume_count", 160'(consume_count), 160'(e.consume_count));
      end
      check_value("ls_valid", 160'(ls_valid), 160'(e.ls_valid));
      if (e.ls_valid) begin
        check_value("ls_op", 160'(ls_op), 160'(e.ls_op));
        check_value("ls_rob_slot", 160'(ls_rob_slot), 160'(e.ls_slot));
      end
      check_value("alu_valid", 160'(alu_valid), 160'(e.alu_valid));
      if (e.alu_valid) begin
        check_value("alu_op", 160'(alu_op), 160'(e.alu_op));
        check_value("alu_rob_slot", 160'(alu_rob_slot), 160'(e.alu_slot));
      end
      check_value("muldiv_valid", 160'(muldiv_valid), 160'(e.muldiv_valid));
      if (e.muldiv_valid) begin
        check_value("muldiv_op", 160'(muldiv_op), 160'(e.muldiv_op));
        check_value("muldiv_rob_slot", 160'(muldiv_rob_slot), 160'(e.muldiv_slot));
      end

      // While the delayed stall is high the captured branch stays in charge
      act_op        = m_stall_d ? m_held_op : e.br_op;
      act_slot      = m_stall_d ? m_held_slot : e.br_slot;
      act_valid     = m_stall_d ? m_held_valid : e.br_issue;
      want_redirect = act_valid &&
                      ((act_op.inst.inst_class == issue_pkg::class_jump) ||
                       ((act_op.inst.inst_class == issue_pkg::class_branch) &&
                        branch_taken(act_op)));
      check_value("redirect_valid", 160'(redirect_valid), 160'(want_redirect));
      if (want_redirect) begin
        check_value("redirect_pc", 160'(redirect_pc),
                    160'(act_op.inst.reg_target ? act_op.operands.a :
                         act_op.inst.branch_target));
      end
      if (act_valid) begin
        check_value("rob_write.result", 160'(rob_write.result), 160'(act_op.inst.pc + 32'd8));
        check_value("rob_write.dest_reg", 160'(rob_write.dest_reg), 160'(act_op.inst.dest_reg));
        check_value("rob_write.dest_reg_valid", 160'(rob_write.dest_reg_valid),
                    160'(act_op.inst.dest_reg_valid));
        check_value("rob_write.pc_valid", 160'(rob_write.pc_valid), 160'(want_redirect));
        check_value("rob_write_slot", 160'(rob_write_slot), 160'(act_slot));
      end
      check_value("rob_write_valid", 160'(rob_write_valid), 160'(!branch_stall));

      for (int i = 0; i < 4; i++) begin
        check_value($sformatf("lookup_areg[%0d]", i), 160'(lookup_areg[i]),
                    160'(entry_inst[i].a_reg));
        check_value($sformatf("lookup_breg[%0d]", i), 160'(lookup_breg[i]),
                    160'(entry_inst[i].b_reg));
        check_value($sformatf("lookup_slot[%0d]", i), 160'(lookup_slot[i]),
                    160'(entry_rob_slot[i]));
        check_value($sformatf("reg_addr[%0d]", 2*i), 160'(reg_addr[2*i]),
                    160'(entry_inst[i].a_reg));
        check_value($sformatf("reg_addr[%0d]", 2*i+1), 160'(reg_addr[2*i+1]),
                    160'(entry_inst[i].b_reg));
      end

      // Capture on the first stalled cycle, as the resolver does at the next edge
      if (branch_stall && !m_stall_d) begin
        m_held_valid = e.br_issue;
        m_held_op    = e.br_op;
        m_held_slot  = e.br_slot;
      end
      m_stall_d = branch_stall;
    end
  end

  function automatic logic [31:0] edge_value(input logic [31:0] other);
    case ($urandom_range(0, 5))
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'h7fff_ffff;
      default: return other;
    endcase
  endfunction

  function automatic issue_pkg::dec_inst_t make_inst(input issue_pkg::inst_class_e cls);
    issue_pkg::dec_inst_t inst;
    inst.pc             = $urandom() & 32'hffff_fffc;
    inst.branch_target  = $urandom() & 32'hffff_fffc;
    inst.a_reg          = 5'($urandom());
    inst.a_reg_valid    = 1'($urandom());
    inst.b_reg          = 5'($urandom());
    inst.b_reg_valid    = 1'($urandom());
    inst.dest_reg       = 5'($urandom());
    inst.dest_reg_valid = 1'($urandom());
    inst.inst_class     = cls;
    inst.branch_cond    = issue_pkg::branch_cond_e'(3'($urandom_range(0, 6)));
    inst.reg_target     = 1'($urandom());
    return inst;
  endfunction

  // Modes follow the test numbers 1 to 6
  task automatic drive_cycle(input int mode);
    int                     n;
    int                     top_class;
    issue_pkg::inst_class_e cls;
    issue_pkg::rob_lookup_t lk;
    top_class = (mode >= 5) ? 5 : 3;
    case (mode)
      4:       n = int'($urandom_range(1, 4));
      5, 6:    n = int'($urandom_range(2, 4));
      default: n = int'($urandom_range(0, 4));
    endcase
    for (int i = 0; i < 4; i++) begin
      cls = issue_pkg::inst_class_e'(3'($urandom_range(0, top_class)));
      // The delay slot test puts its branch last, in slot 3 or before an empty slot
      if ((mode >= 5 && i == 0) || (mode == 4 && i == n - 1)) begin
        cls = ($urandom_range(0, 1) == 1) ? issue_pkg::class_branch : issue_pkg::class_jump;
      end
      lk.a_value   = $urandom();
      lk.b_value   = $urandom();
      lk.a_present = 1'($urandom());
      lk.b_present = 1'($urandom());
      lk.a_valid   = (mode == 2) ? 1'($urandom()) : 1'b1;
      lk.b_valid   = (mode == 2) ? 1'($urandom()) : 1'b1;
      if (mode >= 5 && i == 0) begin
        lk.a_value   = edge_value($urandom());
        lk.b_value   = edge_value(lk.a_value);
        lk.a_present = 1'b1;
        lk.b_present = 1'b1;
      end
      entry_valid[i]    <= (i < n);
      entry_inst[i]     <= make_inst(cls);
      entry_rob_slot[i] <= slot_w'($urandom());
      lookup[i]         <= lk;
    end
    for (int j = 0; j < 8; j++) begin
      reg_data[j] <= $urandom();
    end
    ls_ready     <= (mode == 3) ? 1'($urandom()) : 1'b1;
    alu_ready    <= (mode == 3) ? 1'($urandom()) : 1'b1;
    muldiv_ready <= (mode == 3) ? 1'($urandom()) : 1'b1;
    if (mode == 6) begin
      if ($urandom_range(0, 3) == 0) begin
        branch_stall <= !branch_stall;
      end
    end else begin
      branch_stall <= 1'b0;
    end
  endtask

  task automatic run_test(input int number, input string name, input int cycles);
    int errors_before;
    int checks_before;
    errors_before = error_count;
    checks_before = check_count;
    for (int c = 0; c < cycles; c++) begin
      @(posedge clock);
      drive_cycle(number);
    end
    @(negedge clock);
    #1;
    $display("Test %0d %s: %0d cycles, %0d checks, %0d errors", number, name, cycles,
             check_count - checks_before, error_count - errors_before);
  endtask

  initial begin
    void'($urandom(32'hc32b));
    check_count  = 0;
    error_count  = 0;
    reset_n      = 1'b0;
    ls_ready     = 1'b0;
    alu_ready    = 1'b0;
    muldiv_ready = 1'b0;
    branch_stall = 1'b0;
    for (int i = 0; i < 4; i++) begin
      entry_valid[i]    = 1'b0;
      entry_inst[i]     = '0;
      entry_rob_slot[i] = '0;
      lookup[i]         = '0;
    end
    for (int j = 0; j < 8; j++) begin
      reg_data[j] = '0;
    end
    repeat (reset_cycles) @(posedge clock);
    reset_n <= 1'b1;

    run_test(1, "random unit mix", mix_cycles);
    run_test(2, "operand sourcing", operand_cycles);
    run_test(3, "unit back-pressure", ready_cycles);
    run_test(4, "delay slot rule", delay_cycles);
    run_test(5, "branch outcome", outcome_cycles);
    run_test(6, "fetch stall", stall_cycles);

    $display("Summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: issue_stage.f
hdl/issue_pkg.sv
hdl/operand_gather.sv
hdl/issue_select.sv
hdl/branch_resolve.sv
hdl/issue_stage.sv
tb/issue_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := issue_stage_tb
FILELIST  := issue_stage.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_TEXT := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
